// File: design/game_consts.svh
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// 800x600 timing with horizontal counts in pixel clocks
`define H_ACTIVE 800
`define H_FP 40
`define H_SYNC 128
`define H_TOTAL 1056

// vertical in lines
`define V_ACTIVE 600
`define V_FP 1
`define V_SYNC 4
`define V_TOTAL 628

// first row of the ground
`define GROUND_Y 500

// sprite bounding box
`define PLAYER_W 40
`define PLAYER_H 80

// per-frame movement
`define STEP_X 4
`define JUMP_STEP 6
`define JUMP_MAX 96

// 4:4:4 colours
`define COLOR_SKY 12'h4AF
`define COLOR_GROUND 12'h6A2
`define COLOR_BODY 12'hFFF
`define COLOR_EYE 12'h000

`endif

// File: design/game_pkg.sv
package game_pkg;

    // one pixel slot as it moves down the pipeline
    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_bus_t;

    // sprite shape follows the walking direction
    typedef enum logic [1:0] {
        IDLE,
        LEFT,
        RIGHT
    } player_state_t;

endpackage

// File: design/vga_timing.sv
`timescale 1ns/1ns

`include "game_consts.svh"

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output game_pkg::vga_bus_t bus
);

    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;
    logic        hsync_nxt;
    logic        vsync_nxt;
    logic        hblnk_nxt;
    logic        vblnk_nxt;

    // counters advance every pixel clock
    always_comb begin
        if (bus.hcount == 11'(`H_TOTAL - 1)) begin
            hcount_nxt = '0;
            if (bus.vcount == 11'(`V_TOTAL - 1)) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = bus.vcount + 11'd1;
            end
        end else begin
            hcount_nxt = bus.hcount + 11'd1;
            vcount_nxt = bus.vcount;
        end
    end

    // flags come from the next counts so they line up after the register
    always_comb begin
        hblnk_nxt = (hcount_nxt >= 11'(`H_ACTIVE));
        hsync_nxt = (hcount_nxt >= 11'(`H_ACTIVE + `H_FP)) &&
                    (hcount_nxt <  11'(`H_ACTIVE + `H_FP + `H_SYNC));
        vblnk_nxt = (vcount_nxt >= 11'(`V_ACTIVE));
        vsync_nxt = (vcount_nxt >= 11'(`V_ACTIVE + `V_FP)) &&
                    (vcount_nxt <  11'(`V_ACTIVE + `V_FP + `V_SYNC));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.hcount <= '0;
            bus.vcount <= '0;
            bus.hsync  <= 1'b0;
            bus.vsync  <= 1'b0;
            bus.hblnk  <= 1'b0;
            bus.vblnk  <= 1'b0;
            bus.rgb    <= '0;
        end else begin
            bus.hcount <= hcount_nxt;
            bus.vcount <= vcount_nxt;
            bus.hsync  <= hsync_nxt;
            bus.vsync  <= vsync_nxt;
            bus.hblnk  <= hblnk_nxt;
            bus.vblnk  <= vblnk_nxt;
            // no colour yet as later stages paint it
            bus.rgb    <= '0;
        end
    end

endmodule

// File: design/draw_background.sv
`timescale 1ns/1ns

`include "game_consts.svh"

module draw_background (
    input  logic               clk,
    input  logic               rst,
    input  game_pkg::vga_bus_t bus_in,
    output game_pkg::vga_bus_t bus_out
);

    logic [11:0] rgb_nxt;

    // scene colour for the incoming slot
    always_comb begin
        if (bus_in.hblnk || bus_in.vblnk) begin
            rgb_nxt = 12'h000;
        end else if (bus_in.vcount < 11'(`GROUND_Y)) begin
            rgb_nxt = `COLOR_SKY;
        end else begin
            rgb_nxt = `COLOR_GROUND;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out <= '0;
        end else begin
            // timing fields one cycle later with the colour replaced
            bus_out.hcount <= bus_in.hcount;
            bus_out.vcount <= bus_in.vcount;
            bus_out.hsync  <= bus_in.hsync;
            bus_out.vsync  <= bus_in.vsync;
            bus_out.hblnk  <= bus_in.hblnk;
            bus_out.vblnk  <= bus_in.vblnk;
            bus_out.rgb    <= rgb_nxt;
        end
    end

endmodule

// File: design/player_control.sv
`timescale 1ns/1ns

`include "game_consts.svh"

module player_control (
    input  logic                    clk,
    input  logic                    rst,
    input  game_pkg::vga_bus_t      bus,
    input  logic                    btn_left,
    input  logic                    btn_right,
    input  logic                    btn_jump,
    output logic [10:0]             xpos,
    output logic [10:0]             ypos,
    output game_pkg::player_state_t state
);

    import game_pkg::*;

    logic          frame_tick;
    logic          rising;
    logic          rising_nxt;
    logic [10:0]   xpos_nxt;
    logic [10:0]   ypos_nxt;
    player_state_t state_nxt;

    // first pixel of the vertical blanking
    assign frame_tick = (bus.hcount == 11'd0) && (bus.vcount == 11'(`V_ACTIVE));

    always_comb begin
        xpos_nxt   = xpos;
        ypos_nxt   = ypos;
        state_nxt  = state;
        rising_nxt = rising;

        if (frame_tick) begin
            // walking clamped to the visible width
            if (btn_left && !btn_right) begin
                state_nxt = LEFT;
                if (xpos < 11'(`STEP_X)) begin
                    xpos_nxt = '0;
                end else begin
                    xpos_nxt = xpos - 11'(`STEP_X);
                end
            end else if (btn_right && !btn_left) begin
                state_nxt = RIGHT;
                if (xpos > 11'(`H_ACTIVE - `PLAYER_W - `STEP_X)) begin
                    xpos_nxt = 11'(`H_ACTIVE - `PLAYER_W);
                end else begin
                    xpos_nxt = xpos + 11'(`STEP_X);
                end
            end else begin
                state_nxt = IDLE;
            end

            // jump arc goes up to the top and then back down to the ground
            if (rising) begin
                if (ypos + 11'(`JUMP_STEP) >= 11'(`JUMP_MAX)) begin
                    ypos_nxt   = 11'(`JUMP_MAX);
                    rising_nxt = 1'b0;
                end else begin
                    ypos_nxt = ypos + 11'(`JUMP_STEP);
                end
            end else if (ypos != 11'd0) begin
                if (ypos > 11'(`JUMP_STEP)) begin
                    ypos_nxt = ypos - 11'(`JUMP_STEP);
                end else begin
                    ypos_nxt = '0;
                end
            end else if (btn_jump) begin
                // only a grounded player can take off
                ypos_nxt   = 11'(`JUMP_STEP);
                rising_nxt = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            xpos   <= 11'((`H_ACTIVE - `PLAYER_W) / 2);
            ypos   <= '0;
            state  <= IDLE;
            rising <= 1'b0;
        end else begin
            xpos   <= xpos_nxt;
            ypos   <= ypos_nxt;
            state  <= state_nxt;
            rising <= rising_nxt;
        end
    end

endmodule

// File: design/draw_player.sv
`timescale 1ns/1ns

`include "game_consts.svh"

module draw_player (
    input  logic                    clk,
    input  logic                    rst,
    input  game_pkg::vga_bus_t      bus_in,
    input  logic [10:0]             xpos,
    input  logic [10:0]             ypos,
    input  game_pkg::player_state_t state,
    output game_pkg::vga_bus_t      bus_out
);

    import game_pkg::*;

    vga_bus_t    timing_q;
    logic [11:0] rgb_q;
    logic [11:0] rgb_nxt;
    logic [10:0] origin_y;
    logic [10:0] dx;
    logic [10:0] dy;

    // inclusive rectangle test in sprite coordinates
    function automatic logic in_box(
        input logic [10:0] row,
        input logic [10:0] col,
        input int          r0,
        input int          r1,
        input int          c0,
        input int          c1
    );
        return (row >= r0) && (row <= r1) && (col >= c0) && (col <= c1);
    endfunction

    // pixels left of or above the origin wrap to large offsets and miss every box
    assign origin_y = 11'(`GROUND_Y - `PLAYER_H) - ypos;
    assign dx       = bus_in.hcount - xpos;
    assign dy       = bus_in.vcount - origin_y;

    always_comb begin
        rgb_nxt = bus_in.rgb;
        if (!bus_in.hblnk && !bus_in.vblnk) begin
            case (state)
                IDLE: begin
                    // body then legs with a gap between them
                    if (in_box(dy, dx, 0, 59, 0, 39)) begin
                        rgb_nxt = `COLOR_BODY;
                    end
                    if (in_box(dy, dx, 60, 79, 0, 14) || in_box(dy, dx, 60, 79, 25, 39)) begin
                        rgb_nxt = `COLOR_BODY;
                    end
                    // two eyes facing the viewer
                    if (in_box(dy, dx, 14, 19, 8, 13) || in_box(dy, dx, 14, 19, 26, 31)) begin
                        rgb_nxt = `COLOR_EYE;
                    end
                end
                RIGHT: begin
                    if (in_box(dy, dx, 0, 79, 0, 24)) begin
                        rgb_nxt = `COLOR_BODY;
                    end
                    // eye on the leading edge
                    if (in_box(dy, dx, 5, 34, 25, 29)) begin
                        rgb_nxt = `COLOR_EYE;
                    end
                end
                LEFT: begin
                    if (in_box(dy, dx, 0, 79, 5, 29)) begin
                        rgb_nxt = `COLOR_BODY;
                    end
                    if (in_box(dy, dx, 5, 34, 0, 4)) begin
                        rgb_nxt = `COLOR_EYE;
                    end
                end
                default: begin
                    rgb_nxt = bus_in.rgb;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            timing_q <= '0;
        end else begin
            timing_q <= bus_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_q <= '0;
        end else begin
            rgb_q <= rgb_nxt;
        end
    end

    // delayed timing with the new colour on top
    always_comb begin
        bus_out     = timing_q;
        bus_out.rgb = rgb_q;
    end

endmodule

// File: design/game_top.sv
`timescale 1ns/1ns

module game_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        btn_left,
    input  logic        btn_right,
    input  logic        btn_jump,
    output logic        hsync,
    output logic        vsync,
    output logic [11:0] rgb
);

    import game_pkg::*;

    vga_bus_t      bus_timing;
    vga_bus_t      bus_bg;
    vga_bus_t      bus_out;
    logic [10:0]   xpos;
    logic [10:0]   ypos;
    player_state_t state;

    vga_timing vga_timing_inst (
        .clk (clk),
        .rst (rst),
        .bus (bus_timing)
    );

    draw_background draw_background_inst (
        .clk     (clk),
        .rst     (rst),
        .bus_in  (bus_timing),
        .bus_out (bus_bg)
    );

    // position updates once per frame off the raw timing
    player_control player_control_inst (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus_timing),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_jump  (btn_jump),
        .xpos      (xpos),
        .ypos      (ypos),
        .state     (state)
    );

    draw_player draw_player_inst (
        .clk     (clk),
        .rst     (rst),
        .bus_in  (bus_bg),
        .xpos    (xpos),
        .ypos    (ypos),
        .state   (state),
        .bus_out (bus_out)
    );

    assign hsync = bus_out.hsync;
    assign vsync = bus_out.vsync;
    assign rgb   = bus_out.rgb;

endmodule

// File: verification/game_model.svh
`ifndef GAME_MODEL_SVH
`define GAME_MODEL_SVH

`include "game_consts.svh"

// expected player as it stands after the last frame tick
int            ref_xpos;
int            ref_ypos;
bit            ref_rising;
player_state_t ref_state;

task automatic reset_player();
    ref_xpos   = (`H_ACTIVE - `PLAYER_W) / 2;
    ref_ypos   = 0;
    ref_rising = 1'b0;
    ref_state  = IDLE;
endtask

// one frame of movement and jump from the sampled buttons
task automatic update_player(input bit left, input bit right, input bit jump);
    if (left && !right) begin
        ref_state = LEFT;
        ref_xpos  = ref_xpos - `STEP_X;
    end else if (right && !left) begin
        ref_state = RIGHT;
        ref_xpos  = ref_xpos + `STEP_X;
    end else begin
        ref_state = IDLE;
    end
    if (ref_xpos < 0) begin
        ref_xpos = 0;
    end
    if (ref_xpos > `H_ACTIVE - `PLAYER_W) begin
        ref_xpos = `H_ACTIVE - `PLAYER_W;
    end

    if (ref_rising) begin
        ref_ypos = ref_ypos + `JUMP_STEP;
        if (ref_ypos >= `JUMP_MAX) begin
            ref_ypos   = `JUMP_MAX;
            ref_rising = 1'b0;
        end
    end else if (ref_ypos > 0) begin
        ref_ypos = ref_ypos - `JUMP_STEP;
        if (ref_ypos < 0) begin
            ref_ypos = 0;
        end
    end else if (jump) begin
        ref_ypos   = `JUMP_STEP;
        ref_rising = 1'b1;
    end
endtask

function automatic bit in_rect(int row, int col, int top, int bottom, int left, int right);
    return (row >= top) && (row <= bottom) && (col >= left) && (col <= right);
endfunction

function automatic bit hsync_at(int h);
    return (h >= `H_ACTIVE + `H_FP) && (h < `H_ACTIVE + `H_FP + `H_SYNC);
endfunction

function automatic bit vsync_at(int v);
    return (v >= `V_ACTIVE + `V_FP) && (v < `V_ACTIVE + `V_FP + `V_SYNC);
endfunction

// scene colour with the sprite drawn on top
function automatic logic [11:0] pixel_color(int h, int v);
    logic [11:0] color;
    int          row;
    int          col;
    if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
        return 12'h000;
    end
    color = (v < `GROUND_Y) ? `COLOR_SKY : `COLOR_GROUND;
    row   = v - (`GROUND_Y - `PLAYER_H - ref_ypos);
    col   = h - ref_xpos;
    if (ref_state == IDLE) begin
        if (in_rect(row, col, 0, 59, 0, 39) || in_rect(row, col, 60, 79, 0, 14) ||
            in_rect(row, col, 60, 79, 25, 39)) begin
            color = `COLOR_BODY;
        end
        if (in_rect(row, col, 14, 19, 8, 13) || in_rect(row, col, 14, 19, 26, 31)) begin
            color = `COLOR_EYE;
        end
    end else if (ref_state == RIGHT) begin
        if (in_rect(row, col, 0, 79, 0, 24)) begin
            color = `COLOR_BODY;
        end
        if (in_rect(row, col, 5, 34, 25, 29)) begin
            color = `COLOR_EYE;
        end
    end else begin
        if (in_rect(row, col, 0, 79, 5, 29)) begin
            color = `COLOR_BODY;
        end
        if (in_rect(row, col, 5, 34, 0, 4)) begin
            color = `COLOR_EYE;
        end
    end
    return color;
endfunction

`endif

// File: verification/game_tb.sv
`timescale 1ns/1ns

`include "game_consts.svh"

module game_tb;

    import game_pkg::*;

    `include "game_model.svh"

    localparam int FRAMES       = 8;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int MAX_REPORTS  = 40;

    logic        clk;
    logic        rst;
    logic        btn_left;
    logic        btn_right;
    logic        btn_jump;
    logic        hsync;
    logic        vsync;
    logic [11:0] rgb;

    int seed;
    int errors;
    int checks;
    int reports;
    int frame_errors;
    int frames_failed;
    int frame_idx;
    int slot;
    // position on the timing bus and the one expected on the pins
    int time_h;
    int time_v;
    int out_h;
    int out_v;

    game_top game_top_inst (
        .clk       (clk),
        .rst       (rst),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_jump  (btn_jump),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb       (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // two spare frames beyond the checked ones
    initial begin
        #(64'd1 * (FRAMES + 2) * FRAME_CYCLES * 40);
        $display("Watchdog expired before all frames were checked");
        $display("Test failures found");
        $finish;
    end

    task automatic flag_mismatch(input string name, input int got, input int expected);
        errors++;
        frame_errors++;
        if (reports < MAX_REPORTS) begin
            $display("[FAIL] %0t ns: %s at (%0d,%0d) slot %0d is %h, expected %h",
                     $time, name, out_h, out_v, slot, got, expected);
        end else if (reports == MAX_REPORTS) begin
            $display("Too many mismatches, further ones are only counted");
        end
        reports++;
    endtask

    task automatic step_position(inout int h, inout int v);
        h++;
        if (h == `H_TOTAL) begin
            h = 0;
            v = (v == `V_TOTAL - 1) ? 0 : v + 1;
        end
    endtask

    task automatic check_output();
        logic        exp_hsync;
        logic        exp_vsync;
        logic [11:0] exp_rgb;
        // pipeline still holds reset values for two slots
        if (slot < 2) begin
            exp_hsync = 1'b0;
            exp_vsync = 1'b0;
            exp_rgb   = 12'h000;
        end else begin
            exp_hsync = hsync_at(out_h);
            exp_vsync = vsync_at(out_v);
            exp_rgb   = pixel_color(out_h, out_v);
        end
        checks++;
        assert (hsync === exp_hsync) else flag_mismatch("hsync", hsync, exp_hsync);
        assert (vsync === exp_vsync) else flag_mismatch("vsync", vsync, exp_vsync);
        assert (rgb === exp_rgb) else flag_mismatch("rgb", rgb, exp_rgb);
    endtask

    task automatic pick_buttons();
        int bits;
        bits      = $random(seed);
        btn_left  = bits[0];
        btn_right = bits[1];
        btn_jump  = bits[2];
    endtask

    initial begin
        seed          = 29382;
        errors        = 0;
        checks        = 0;
        reports       = 0;
        frame_errors  = 0;
        frames_failed = 0;
        frame_idx     = 0;
        time_h        = 0;
        time_v        = 0;
        out_h         = 0;
        out_v         = 0;
        rst           = 1'b1;
        btn_left      = 1'b0;
        btn_right     = 1'b0;
        btn_jump      = 1'b0;
        reset_player();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (slot = 0; slot < FRAMES * FRAME_CYCLES + 2; slot++) begin
            if (slot > 0) begin
                @(negedge clk);
            end
            check_output();
            // buttons seen by the DUT on the coming edge
            if (time_h == 0 && time_v == `V_ACTIVE) begin
                update_player(btn_left, btn_right, btn_jump);
            end
            if (time_h == 0 && time_v == 0 && slot > 0) begin
                pick_buttons();
            end
            step_position(time_h, time_v);
            if (slot >= 2) begin
                if (out_h == `H_TOTAL - 1 && out_v == `V_TOTAL - 1) begin
                    $display("frame %0d: %0d mismatches, next sprite %s at x=%0d y=%0d",
                             frame_idx, frame_errors, ref_state.name(), ref_xpos, ref_ypos);
                    if (frame_errors != 0) begin
                        frames_failed++;
                    end
                    frame_errors = 0;
                    frame_idx++;
                end
                step_position(out_h, out_v);
            end
        end

        $display("%0d frames, %0d failed, %0d pixels checked, %0d errors",
                 frame_idx, frames_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+design
+incdir+verification
design/game_pkg.sv
design/vga_timing.sv
design/draw_background.sv
design/player_control.sv
design/draw_player.sv
design/game_top.sv
verification/game_tb.sv
